//--- include/rast_cfg.svh
`ifndef RAST_CFG_SVH
`define RAST_CFG_SVH

// Fixed-point format shared by the raster stage
// Integer part is SIGFIG-RADIX bits
`define RAST_SIGFIG 24   // Bits per position and color value
`define RAST_RADIX  10   // Fraction bits

// Triangle geometry
`define RAST_VERTS  3    // Vertices per triangle
`define RAST_AXIS   3    // Axes per vertex (x y z)

// Shading
`define RAST_COLORS 3    // Color channels

// Code 1000 is one sample per pixel
// Each step down the one-hot code halves the sample pitch

`endif

//--- verilog/rast_pkg.sv
`default_nettype none

`include "rast_cfg.svh"

// Types shared by the raster iterator
package rast_pkg;

    // Signed fixed-point position
    typedef logic signed [`RAST_SIGFIG-1:0] coord_t;

    // Unsigned color channel
    typedef logic [`RAST_SIGFIG-1:0] color_t;

    // One-hot MSAA code (1000 1x  0100 4x  0010 16x  0001 64x)
    typedef logic [3:0] subsample_t;

    // Iterator states
    typedef enum logic {
        WAIT_STATE,   // Idle until a valid triangle
        TEST_STATE    // Walking the box
    } iter_state_t;

endpackage

`default_nettype wire

//--- verilog/quad_stepper.sv
`timescale 1ns/1ns
`default_nettype none

`include "rast_cfg.svh"

// Walks a bounding box in 2x2 sample quads
// Left to right then bottom to top
// Sample order in a quad is lower left, lower right, upper left, upper right
module quad_stepper (
    input  wire                       clk,                  // Clock
    input  wire                       rst,                  // Async reset
    input  wire                       load,                 // Capture box and restart
    input  wire rast_pkg::coord_t     box_R13S [1:0][1:0],  // Incoming box [corner][axis]
    input  wire rast_pkg::subsample_t subSample_RnnnnU,     // MSAA code
    output logic                      box_end,              // Current quad closes the box
    output rast_pkg::coord_t          sample_R14S_1 [1:0],  // (x, y)
    output rast_pkg::coord_t          sample_R14S_2 [1:0],  // (x+d, y)
    output rast_pkg::coord_t          sample_R14S_3 [1:0],  // (x, y+d)
    output rast_pkg::coord_t          sample_R14S_4 [1:0]   // (x+d, y+d)
);

    rast_pkg::coord_t     box_R14S [1:0][1:0];  // Held box
    rast_pkg::subsample_t sub_R14U;             // Held MSAA code
    rast_pkg::subsample_t sub_sel;              // Code in use this cycle
    rast_pkg::coord_t     samp_d;               // One sample apart
    rast_pkg::coord_t     samp_2d;              // Quad stride
    rast_pkg::coord_t     next_x;               // Next quad origin x
    rast_pkg::coord_t     next_y;               // Next quad origin y
    logic                 at_right_edg;         // Right column of the box
    logic                 at_top_edg;           // Top row of the box

    // Incoming code while loading, held code while walking
    assign sub_sel = load ? subSample_RnnnnU : sub_R14U;

    // Sample pitch from the one-hot code
    // Bit 3 of the code lands on the integer LSB
    assign samp_d = {{(`RAST_SIGFIG - `RAST_RADIX - 1){1'b0}},
                     sub_sel,
                     {(`RAST_RADIX - 3){1'b0}}};

    // Quads advance by two samples
    assign samp_2d = {samp_d[`RAST_SIGFIG-2:0], 1'b0};

    // Edge tests on the right-hand and upper samples of the quad
    assign at_right_edg = (sample_R14S_2[0] >= box_R14S[1][0]);
    assign at_top_edg   = (sample_R14S_3[1] >= box_R14S[1][1]);
    assign box_end      = at_right_edg && at_top_edg;

    // Origin of the next quad
    always_comb begin
        if (load) begin
            // Lower left of the incoming box
            next_x = box_R13S[0][0];
            next_y = box_R13S[0][1];
        end else if (box_end) begin
            // Park at lower left of the held box
            next_x = box_R14S[0][0];
            next_y = box_R14S[0][1];
        end else if (at_right_edg) begin
            // Wrap to left column one row of quads up
            next_x = box_R14S[0][0];
            next_y = sample_R14S_1[1] + samp_2d;
        end else begin
            next_x = sample_R14S_1[0] + samp_2d;   // Step right
            next_y = sample_R14S_1[1];
        end
    end

    // Box and code follow the input only while loading
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            box_R14S <= '{default: '0};
            sub_R14U <= '0;
        end else if (load) begin
            box_R14S <= box_R13S;
            sub_R14U <= subSample_RnnnnU;
        end
    end

    // Four sample registers
    // All four derive from the one origin
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sample_R14S_1 <= '{default: '0};
            sample_R14S_2 <= '{default: '0};
            sample_R14S_3 <= '{default: '0};
            sample_R14S_4 <= '{default: '0};
        end else begin
            sample_R14S_1[0] <= next_x;
            sample_R14S_1[1] <= next_y;

            sample_R14S_2[0] <= next_x + samp_d;  // One sample right
            sample_R14S_2[1] <= next_y;

            sample_R14S_3[0] <= next_x;
            sample_R14S_3[1] <= next_y + samp_d;  // One sample up

            sample_R14S_4[0] <= next_x + samp_d;  // Diagonal
            sample_R14S_4[1] <= next_y + samp_d;
        end
    end

endmodule

`default_nettype wire

//--- verilog/iter_fsm.sv
`timescale 1ns/1ns
`default_nettype none

`include "rast_cfg.svh"

// Wait/test control for the box iterator
// Moore machine with registered valid and halt
module iter_fsm (
    input  wire                   clk,            // Clock
    input  wire                   rst,            // Async reset
    input  wire                   validTri_R13H,  // Triangle offered upstream
    input  wire                   box_end,        // Last quad of the box
    input  wire rast_pkg::coord_t tri_R13S [`RAST_VERTS-1:0][`RAST_AXIS-1:0],
    input  wire rast_pkg::color_t color_R13U [`RAST_COLORS-1:0],
    output logic                  load,           // Stepper captures the box
    output rast_pkg::coord_t      tri_R14S [`RAST_VERTS-1:0][`RAST_AXIS-1:0],
    output rast_pkg::color_t      color_R14U [`RAST_COLORS-1:0],
    output logic                  validSamp_R14H, // Quad and triangle valid
    output logic                  halt_RnnnnL     // Low holds the upstream pipe
);

    rast_pkg::iter_state_t state_R14H;       // Current state
    rast_pkg::iter_state_t next_state_R14H;  // Next cycle state

    // Idle state accepts a new triangle
    assign load = (state_R14H == rast_pkg::WAIT_STATE);

    always_comb begin
        next_state_R14H = state_R14H;
        case (state_R14H)
            rast_pkg::WAIT_STATE: begin
                if (validTri_R13H) begin
                    next_state_R14H = rast_pkg::TEST_STATE;
                end
            end
            rast_pkg::TEST_STATE: begin
                if (box_end) begin
                    next_state_R14H = rast_pkg::WAIT_STATE;  // Box done
                end
            end
            default: next_state_R14H = rast_pkg::WAIT_STATE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_R14H <= rast_pkg::WAIT_STATE;
        end else begin
            state_R14H <= next_state_R14H;
        end
    end

    // Valid and halt track the next state
    // So the first quad shows with valid already high
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            validSamp_R14H <= 1'b0;
            halt_RnnnnL    <= 1'b1;    // Nothing to iterate yet
        end else begin
            validSamp_R14H <= (next_state_R14H == rast_pkg::TEST_STATE);
            halt_RnnnnL    <= (next_state_R14H != rast_pkg::TEST_STATE);
        end
    end

    // Triangle and colors frozen for the whole walk
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tri_R14S   <= '{default: '0};
            color_R14U <= '{default: '0};
        end else if (load) begin
            tri_R14S   <= tri_R13S;
            color_R14U <= color_R13U;
        end
    end

endmodule

`default_nettype wire

//--- verilog/test_iterator.sv
`timescale 1ns/1ns
`default_nettype none

`include "rast_cfg.svh"

// Bounding box sample iterator for the raster stage
// Presents one 2x2 quad per cycle with the held triangle beside it
module test_iterator (
    input  wire                       clk,                  // Clock
    input  wire                       rst,                  // Async reset
    input  wire rast_pkg::coord_t     tri_R13S [`RAST_VERTS-1:0][`RAST_AXIS-1:0],
    input  wire rast_pkg::color_t     color_R13U [`RAST_COLORS-1:0],
    input  wire rast_pkg::coord_t     box_R13S [1:0][1:0],  // Lower left then upper right
    input  wire                       validTri_R13H,        // Triangle valid
    input  wire rast_pkg::subsample_t subSample_RnnnnU,     // MSAA code
    output rast_pkg::coord_t          tri_R14S [`RAST_VERTS-1:0][`RAST_AXIS-1:0],
    output rast_pkg::color_t          color_R14U [`RAST_COLORS-1:0],
    output logic                      validSamp_R14H,       // Quad valid
    output logic                      halt_RnnnnL,          // Hold upstream when low
    output rast_pkg::coord_t          sample_R14S_1 [1:0],
    output rast_pkg::coord_t          sample_R14S_2 [1:0],
    output rast_pkg::coord_t          sample_R14S_3 [1:0],
    output rast_pkg::coord_t          sample_R14S_4 [1:0]
);

    logic load;     // FSM idle so stepper reloads
    logic box_end;  // Stepper reached last quad

    // Quad positions and end-of-box
    quad_stepper quad_stepper_i (
        .clk              (clk),
        .rst              (rst),
        .load             (load),
        .box_R13S         (box_R13S),
        .subSample_RnnnnU (subSample_RnnnnU),
        .box_end          (box_end),
        .sample_R14S_1    (sample_R14S_1),
        .sample_R14S_2    (sample_R14S_2),
        .sample_R14S_3    (sample_R14S_3),
        .sample_R14S_4    (sample_R14S_4)
    );

    // State, handshake levels and triangle hold
    iter_fsm iter_fsm_i (
        .clk            (clk),
        .rst            (rst),
        .validTri_R13H  (validTri_R13H),
        .box_end        (box_end),
        .tri_R13S       (tri_R13S),
        .color_R13U     (color_R13U),
        .load           (load),
        .tri_R14S       (tri_R14S),
        .color_R14U     (color_R14U),
        .validSamp_R14H (validSamp_R14H),
        .halt_RnnnnL    (halt_RnnnnL)
    );

endmodule

`default_nettype wire

//--- verification/test_iterator_sva.sv
`timescale 1ns/1ns
`default_nettype none

`include "rast_cfg.svh"

// Protocol checks on the iterator ports
module test_iterator_sva (
    input wire                   clk,
    input wire                   rst,
    input wire                   validTri_R13H,
    input wire                   validSamp_R14H,
    input wire                   halt_RnnnnL,
    input wire rast_pkg::coord_t box_R13S [1:0][1:0],
    input wire rast_pkg::coord_t sample_R14S_1 [1:0]
);

    rast_pkg::coord_t cap_box [1:0][1:0];  // Box taken at acceptance
    logic             seen_tri;            // A triangle has been accepted

    // Halt high means the iterator is idle and takes the triangle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cap_box  <= '{default: '0};
            seen_tri <= 1'b0;
        end else if (validTri_R13H && halt_RnnnnL) begin
            cap_box  <= box_R13S;
            seen_tri <= 1'b1;
        end
    end

    a_halt_inv: assert property (@(posedge clk) disable iff (rst)
        halt_RnnnnL == !validSamp_R14H)
        else $error("halt is not the inverse of valid");

    a_in_box: assert property (@(posedge clk) disable iff (rst)
        validSamp_R14H |->
            (sample_R14S_1[0] >= cap_box[0][0]) && (sample_R14S_1[0] <= cap_box[1][0])
            && (sample_R14S_1[1] >= cap_box[0][1]) && (sample_R14S_1[1] <= cap_box[1][1]))
        else $error("quad origin outside captured box");

    a_rise_after_tri: assert property (@(posedge clk) disable iff (rst)
        $rose(validSamp_R14H) |-> $past(validTri_R13H))
        else $error("valid rose without a triangle");

    a_quiet_at_start: assert property (@(posedge clk) disable iff (rst)
        !seen_tri |-> !validSamp_R14H)
        else $error("valid before any triangle");

endmodule

bind test_iterator test_iterator_sva test_iterator_sva_i (.*);

`default_nettype wire

//--- verification/tb_test_iterator.sv
`timescale 1ns/1ns
`default_nettype none

`include "rast_cfg.svh"

module tb_test_iterator;

    logic                 clk;
    logic                 rst;
    rast_pkg::coord_t     tri_R13S [`RAST_VERTS-1:0][`RAST_AXIS-1:0];
    rast_pkg::color_t     color_R13U [`RAST_COLORS-1:0];
    rast_pkg::coord_t     box_R13S [1:0][1:0];
    logic                 validTri_R13H;
    rast_pkg::subsample_t subSample_RnnnnU;
    rast_pkg::coord_t     tri_R14S [`RAST_VERTS-1:0][`RAST_AXIS-1:0];
    rast_pkg::color_t     color_R14U [`RAST_COLORS-1:0];
    logic                 validSamp_R14H;
    logic                 halt_RnnnnL;
    rast_pkg::coord_t     sample_R14S_1 [1:0];
    rast_pkg::coord_t     sample_R14S_2 [1:0];
    rast_pkg::coord_t     sample_R14S_3 [1:0];
    rast_pkg::coord_t     sample_R14S_4 [1:0];

    // Stimulus table
    logic [3:0]       st_code [0:15];
    rast_pkg::coord_t st_box  [0:15][0:3];  // x0 y0 x1 y1
    rast_pkg::color_t st_col  [0:15][0:2];
    int               st_cnt  [0:15];
    int               n_lines;

    rast_pkg::coord_t exp_tri [`RAST_VERTS-1:0][`RAST_AXIS-1:0];  // Held at acceptance
    int               err_cnt [0:3];   // quad, hold, count, ctrl
    int               seed;
    int               cyc;
    int               limit;
    logic             seen_tri;
    int               t;

    test_iterator test_iterator_i (.*);

    always #4 clk = ~clk;  // 8 ns period

    // Timeout guard
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= limit) begin
            $display("Timeout after %0d cycles, iterator did not finish", cyc);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    always @(posedge clk) begin
        if (!rst && validTri_R13H && halt_RnnnnL) seen_tri <= 1'b1;  // Accept edge
    end

    // Control levels on every cycle, mid period
    always @(negedge clk) begin
        if (!rst) begin
            if (halt_RnnnnL !== ~validSamp_R14H) begin
                $display("ERR halt_inverse exp=%b act=%b", ~validSamp_R14H, halt_RnnnnL);
                err_cnt[3]++;
            end
            if (!seen_tri && (validSamp_R14H !== 1'b0 || halt_RnnnnL !== 1'b1)) begin
                $display("ERR idle_after_reset exp=01 act=%b%b", validSamp_R14H, halt_RnnnnL);
                err_cnt[3]++;
            end
        end
    end

    task compare(input string name, input int cat, input logic [31:0] exp,
                 input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s exp=%h act=%h", name, exp, act);
            err_cnt[cat]++;
        end
    endtask

    task read_stimulus();
        int          fd;
        int          n;
        string       line;
        logic [31:0] c, x0, y0, x1, y1, r, g, b;
        int          cnt;
        fd = $fopen("verification/iter_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file");
            $display("FAIL: see errors above");
            $finish;
        end else begin
            n_lines = 0;
            limit = 50;
            while (!$feof(fd) && n_lines < 16) begin
                n = $fgets(line, fd);
                if (line.len() > 2 && line[0] != "#") begin
                    n = $sscanf(line, "%b %h %h %h %h %h %h %h %d",
                                c, x0, y0, x1, y1, r, g, b, cnt);
                    if (n == 9) begin
                        st_code[n_lines] = c[3:0];
                        st_box[n_lines][0] = x0;
                        st_box[n_lines][1] = y0;
                        st_box[n_lines][2] = x1;
                        st_box[n_lines][3] = y1;
                        st_col[n_lines][0] = r;
                        st_col[n_lines][1] = g;
                        st_col[n_lines][2] = b;
                        st_cnt[n_lines] = cnt;
                        limit = limit + cnt + 3;  // Quads plus accept and gap
                        n_lines++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Random values on every data input, validTri stays low
    task drive_garbage();
        for (int v = 0; v < `RAST_VERTS; v++)
            for (int a = 0; a < `RAST_AXIS; a++)
                tri_R13S[v][a] <= $random(seed);
        for (int k = 0; k < `RAST_COLORS; k++) color_R13U[k] <= $random(seed);
        for (int k = 0; k < 4; k++) box_R13S[k/2][k%2] <= $random(seed);
        subSample_RnnnnU <= $random(seed);
        validTri_R13H    <= 1'b0;
    endtask

    task offer_triangle(input int i);
        for (int v = 0; v < `RAST_VERTS; v++)
            for (int a = 0; a < `RAST_AXIS; a++) begin
                exp_tri[v][a] = $random(seed);
                tri_R13S[v][a] <= exp_tri[v][a];
            end
        for (int k = 0; k < `RAST_COLORS; k++) color_R13U[k] <= st_col[i][k];
        for (int k = 0; k < 4; k++) box_R13S[k/2][k%2] <= st_box[i][k];
        subSample_RnnnnU <= st_code[i];
        validTri_R13H    <= 1'b1;
    endtask

    // Reference walk over the box, one quad per valid cycle
    task walk_box(input int i);
        rast_pkg::coord_t d, d2, mx, my, rx, ty;
        int               q;
        int               nvalid;
        logic             done;
        d = '0;
        d[3:0] = st_code[i];
        d = d << (`RAST_RADIX - 3);  // 1000 is one pixel
        d2 = d + d;
        mx = st_box[i][0];
        my = st_box[i][1];
        q = 0;
        nvalid = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            compare($sformatf("tri%0d quad%0d valid", i, q), 0, 1, validSamp_R14H);
            if (validSamp_R14H === 1'b1) nvalid++;
            rx = mx + d;
            ty = my + d;
            compare($sformatf("tri%0d quad%0d s1x", i, q), 0, mx, sample_R14S_1[0]);
            compare($sformatf("tri%0d quad%0d s1y", i, q), 0, my, sample_R14S_1[1]);
            compare($sformatf("tri%0d quad%0d s2x", i, q), 0, rx, sample_R14S_2[0]);
            compare($sformatf("tri%0d quad%0d s2y", i, q), 0, my, sample_R14S_2[1]);
            compare($sformatf("tri%0d quad%0d s3x", i, q), 0, mx, sample_R14S_3[0]);
            compare($sformatf("tri%0d quad%0d s3y", i, q), 0, ty, sample_R14S_3[1]);
            compare($sformatf("tri%0d quad%0d s4x", i, q), 0, rx, sample_R14S_4[0]);
            compare($sformatf("tri%0d quad%0d s4y", i, q), 0, ty, sample_R14S_4[1]);
            for (int v = 0; v < `RAST_VERTS; v++)
                for (int a = 0; a < `RAST_AXIS; a++)
                    compare($sformatf("tri%0d quad%0d tri[%0d][%0d]", i, q, v, a), 1,
                            exp_tri[v][a], tri_R14S[v][a]);
            for (int k = 0; k < `RAST_COLORS; k++)
                compare($sformatf("tri%0d quad%0d color[%0d]", i, q, k), 1,
                        st_col[i][k], color_R14U[k]);
            if (rx >= st_box[i][2] && ty >= st_box[i][3]) begin
                done = 1'b1;                // Last quad of the box
            end else begin
                if (rx >= st_box[i][2]) begin
                    mx = st_box[i][0];      // Wrap to the left column
                    my = my + d2;
                end else begin
                    mx = mx + d2;
                end
                q++;
                @(posedge clk);
                drive_garbage();
            end
        end
        compare($sformatf("tri%0d quad_count", i), 2, st_cnt[i], nvalid);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        validTri_R13H = 1'b0;
        subSample_RnnnnU = 4'b1000;
        tri_R13S = '{default: '0};
        color_R13U = '{default: '0};
        box_R13S = '{default: '0};
        exp_tri = '{default: '0};
        err_cnt = '{default: 0};
        seed = 7;
        cyc = 0;
        limit = 1000000;
        seen_tri = 1'b0;
        read_stimulus();
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        for (t = 0; t < n_lines; t++) begin
            @(posedge clk);
            offer_triangle(t);
            @(negedge clk);  // Gap cycle before acceptance
            compare($sformatf("tri%0d gap valid", t), 3, 0, validSamp_R14H);
            compare($sformatf("tri%0d gap halt", t), 3, 1, halt_RnnnnL);
            @(posedge clk);
            drive_garbage();
            walk_box(t);
        end
        @(posedge clk);
        @(negedge clk);
        compare("final valid", 3, 0, validSamp_R14H);
        $display("Errors: quad=%0d hold=%0d count=%0d ctrl=%0d",
                 err_cnt[0], err_cnt[1], err_cnt[2], err_cnt[3]);
        if (err_cnt[0] + err_cnt[1] + err_cnt[2] + err_cnt[3] == 0 && n_lines > 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
verilog/rast_pkg.sv
verilog/quad_stepper.sv
verilog/iter_fsm.sv
verilog/test_iterator.sv
verification/test_iterator_sva.sv
verification/tb_test_iterator.sv

//--- Bender.yml
package:
  name: test_iterator

export_include_dirs:
  - include

sources:
  - verilog/rast_pkg.sv
  - verilog/quad_stepper.sv
  - verilog/iter_fsm.sv
  - verilog/test_iterator.sv
  - target: test
    files:
      - verification/test_iterator_sva.sv
      - verification/tb_test_iterator.sv

//--- verification/iter_stimulus.txt
# code(bin) box_x0 box_y0 box_x1 box_y1 (hex, 10 fraction bits) red green blue (hex) quads(dec)
# One triangle per line, vertices come from the testbench
1000 000000 000000 001000 000800 0000ff 00ff00 ff0000 6
0100 000400 000400 000800 000600 123456 abcdef 0f0f0f 2
0010 000100 000200 000400 000500 000001 000002 000003 4
0001 000000 000000 000200 000180 fedcba 765432 c0ffee 6
1000 000800 000800 000800 000800 111111 222222 333333 1
0100 000000 000000 000600 000200 aaaaaa 555555 808080 2
